//--- source/osCheckPkg.sv
package osCheckPkg;

    // ########################################################################
    // Basic types
    // ########################################################################

    typedef logic [7:0]   symbol_t;
    typedef logic [127:0] orderedSet_t;

    // ########################################################################
    // Symbols
    // ########################################################################

    localparam symbol_t symbolPad    = 8'hF7;  // Link or lane not yet assigned.
    localparam symbol_t symbolCom    = 8'hBC;  // Gen1/2 start.
    localparam symbol_t idTs1        = 8'h4A;
    localparam symbol_t idTs2        = 8'h45;
    localparam symbol_t startGen3Ts1 = 8'h1E;
    localparam symbol_t startGen3Ts2 = 8'h2D;

    // ########################################################################
    // Field positions inside one ordered set
    // ########################################################################

    localparam int startLsb       = 0;   // Symbol 0.
    localparam int linkLsb        = 8;   // Symbol 1.
    localparam int laneLsb        = 16;  // Symbol 2.
    localparam int rateLsb        = 32;  // Symbol 4.
    localparam int upconfigureBit = 42;
    localparam int complianceBit  = 43;
    localparam int idLsb          = 80;  // Symbol 10.

    // ########################################################################
    // Enums
    // ########################################################################

    typedef enum logic [3:0]
    {
        detectQuiet                  = 4'd0,
        detectActive                 = 4'd1,
        pollingActive                = 4'd2,
        pollingConfiguration         = 4'd3,
        configurationLinkWidthStart  = 4'd4,
        configurationLinkWidthAccept = 4'd5,
        configurationLanenumWait     = 4'd6,
        configurationLanenumAccept   = 4'd7,
        configurationComplete        = 4'd8,
        configurationIdle            = 4'd9
    } ltssmSubstate_t;

    typedef enum logic [1:0]
    {
        kindOther,
        kindTs1,
        kindTs2,
        kindIdle
    } osKind_t;

    typedef enum logic [1:0]
    {
        matchIdle,
        matchHunt,
        matchRun
    } matchState_t;

endpackage

//--- source/osFieldsIf.sv
`timescale 1ns/100ps

interface osFieldsIf;

    logic                setValid;     // High for one cycle per accepted set.
    osCheckPkg::osKind_t kind;
    osCheckPkg::symbol_t linkField;
    osCheckPkg::symbol_t laneField;
    osCheckPkg::symbol_t rateField;
    logic                upconfigure;
    logic                compliance;

    modport producer
    (
        output setValid,
        output kind,
        output linkField,
        output laneField,
        output rateField,
        output upconfigure,
        output compliance
    );

    modport consumer
    (
        input setValid,
        input kind,
        input linkField,
        input laneField,
        input rateField,
        input upconfigure,
        input compliance
    );

endinterface

//--- source/osDecoder.sv
`timescale 1ns/100ps

module osDecoder
(
    input  logic                    clk,
    input  logic                    reset,
    input  osCheckPkg::orderedSet_t orderedSet,
    input  logic                    valid,
    osFieldsIf.producer             fields
);

    osCheckPkg::symbol_t startSymbol;
    osCheckPkg::symbol_t idSymbol;
    logic                ts1Start;
    logic                ts2Start;
    logic                allZero;
    osCheckPkg::osKind_t kindNext;

    // ########################################################################
    // Classification of the incoming set
    // ########################################################################

    assign startSymbol = orderedSet[osCheckPkg::startLsb +: 8];
    assign idSymbol    = orderedSet[osCheckPkg::idLsb +: 8];

    assign ts1Start = (startSymbol == osCheckPkg::symbolCom) ||
                      (startSymbol == osCheckPkg::startGen3Ts1);  // Gen1/2 or Gen3.
    assign ts2Start = (startSymbol == osCheckPkg::symbolCom) ||
                      (startSymbol == osCheckPkg::startGen3Ts2);
    assign allZero  = (orderedSet == '0);

    always_comb
    begin
        if (allZero)
        begin
            kindNext = osCheckPkg::kindIdle;
        end
        else if (ts1Start && (idSymbol == osCheckPkg::idTs1))
        begin
            kindNext = osCheckPkg::kindTs1;
        end
        else if (ts2Start && (idSymbol == osCheckPkg::idTs2))
        begin
            kindNext = osCheckPkg::kindTs2;
        end
        else
        begin
            kindNext = osCheckPkg::kindOther;
        end
    end

    // ########################################################################
    // Registered view of the set
    // ########################################################################

    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            fields.setValid <= 1'b0;
        end
        else
        begin
            fields.setValid <= valid;  // No back-pressure.
        end
    end

    always_ff @(posedge clk)
    begin
        if (valid)
        begin
            fields.kind        <= kindNext;
            fields.linkField   <= orderedSet[osCheckPkg::linkLsb +: 8];
            fields.laneField   <= orderedSet[osCheckPkg::laneLsb +: 8];
            fields.rateField   <= orderedSet[osCheckPkg::rateLsb +: 8];
            fields.upconfigure <= orderedSet[osCheckPkg::upconfigureBit];
            fields.compliance  <= orderedSet[osCheckPkg::complianceBit];
        end
    end

endmodule

//--- source/osMatchFsm.sv
`timescale 1ns/100ps

module osMatchFsm
#(
    parameter bit isUpstream = 1'b0
)
(
    input  logic                       clk,
    input  logic                       reset,
    input  osCheckPkg::ltssmSubstate_t substate,
    input  osCheckPkg::symbol_t        linkNumber,
    input  osCheckPkg::symbol_t        laneNumber,
    osFieldsIf.consumer                fields,
    input  logic                       fieldsChanged,
    output logic                       countUp,
    output logic                       countKeep
);

    osCheckPkg::matchState_t    state;
    osCheckPkg::matchState_t    stateNext;
    osCheckPkg::ltssmSubstate_t heldSubstate;
    osCheckPkg::ltssmSubstate_t ruleSubstate;
    osCheckPkg::symbol_t        learnedLink;
    logic                       isTs1;
    logic                       isTs2;
    logic                       linkPad;
    logic                       lanePad;
    logic                       linkMatch;
    logic                       laneMatch;
    logic                       learnedOk;
    logic                       match;
    logic                       setMatch;
    logic                       substateLeft;

    // ########################################################################
    // Rule selection and field tests
    // ########################################################################

    // In idle the live substate picks the rule.
    assign ruleSubstate = (state == osCheckPkg::matchIdle) ? substate : heldSubstate;

    assign isTs1     = (fields.kind == osCheckPkg::kindTs1);
    assign isTs2     = (fields.kind == osCheckPkg::kindTs2);
    assign linkPad   = (fields.linkField == osCheckPkg::symbolPad);
    assign lanePad   = (fields.laneField == osCheckPkg::symbolPad);
    assign linkMatch = (fields.linkField == linkNumber);
    assign laneMatch = (fields.laneField == laneNumber);

    // Upstream learns any assigned link, then holds to it while running.
    assign learnedOk = (state == osCheckPkg::matchRun) ? (fields.linkField == learnedLink)
                                                       : !linkPad;

    always_comb
    begin
        match = 1'b0;
        case (ruleSubstate)
            osCheckPkg::pollingActive:
                match = (isTs2 || (isTs1 && (!fields.compliance || fields.upconfigure))) &&
                        linkPad && lanePad;
            osCheckPkg::pollingConfiguration:
                match = isTs2 && linkPad && lanePad;
            osCheckPkg::configurationLinkWidthStart:
                match = isTs1 && lanePad && (isUpstream ? learnedOk : linkMatch);
            osCheckPkg::configurationLinkWidthAccept:
                match = isUpstream && isTs1 && linkMatch && !lanePad;  // Upstream only.
            osCheckPkg::configurationLanenumWait,
            osCheckPkg::configurationLanenumAccept:
                match = (isUpstream ? isTs2 : isTs1) && linkMatch && laneMatch;
            osCheckPkg::configurationComplete:
                match = isTs2 && linkMatch && laneMatch &&
                        !((state == osCheckPkg::matchRun) && fieldsChanged);
            osCheckPkg::configurationIdle:
                match = (fields.kind == osCheckPkg::kindIdle);
            default:
                match = 1'b0;  // Detect substates are not checked.
        endcase
    end

    assign setMatch     = fields.setValid && match;
    assign substateLeft = (state != osCheckPkg::matchIdle) && (substate != heldSubstate);

    // ########################################################################
    // Matching machine
    // ########################################################################

    always_comb
    begin
        stateNext = state;
        case (state)
            osCheckPkg::matchIdle,
            osCheckPkg::matchHunt:
                if (setMatch)
                begin
                    stateNext = osCheckPkg::matchRun;
                end
            osCheckPkg::matchRun:
                if (fields.setValid && !match)
                begin
                    stateNext = osCheckPkg::matchHunt;
                end
            default:
                stateNext = osCheckPkg::matchIdle;
        endcase
        if (substateLeft)
        begin
            stateNext = osCheckPkg::matchIdle;  // New substate, start over.
        end
    end

    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            state        <= osCheckPkg::matchIdle;
            heldSubstate <= osCheckPkg::detectQuiet;
            learnedLink  <= '0;
        end
        else
        begin
            state <= stateNext;
            if ((state == osCheckPkg::matchIdle) && setMatch)
            begin
                heldSubstate <= substate;
            end
            if (setMatch && (state != osCheckPkg::matchRun) &&
                (ruleSubstate == osCheckPkg::configurationLinkWidthStart))
            begin
                learnedLink <= fields.linkField;
            end
        end
    end

    assign countUp   = setMatch;
    assign countKeep = (state == osCheckPkg::matchRun) || setMatch;  // Hold through the run.

endmodule

//--- source/osCapture.sv
`timescale 1ns/100ps

module osCapture
(
    input  logic                clk,
    input  logic                reset,
    osFieldsIf.consumer         fields,
    output logic                fieldsChanged,
    output osCheckPkg::symbol_t rateId,
    output osCheckPkg::symbol_t linkNumberOut,
    output logic                upconfigureCapable
);

    logic rateDiffers;
    logic upconfigureDiffers;

    // ########################################################################
    // Change detection against the held set
    // ########################################################################

    assign rateDiffers        = (fields.rateField != rateId);
    assign upconfigureDiffers = (fields.upconfigure != upconfigureCapable);

    // Only meaningful while a new set is on the bus.
    assign fieldsChanged = fields.setValid && (rateDiffers || upconfigureDiffers);

    // ########################################################################
    // Held fields of the last set
    // ########################################################################

    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            rateId             <= '0;
            linkNumberOut      <= '0;
            upconfigureCapable <= 1'b0;
        end
        else if (fields.setValid)
        begin
            rateId             <= fields.rateField;
            linkNumberOut      <= fields.linkField;
            upconfigureCapable <= fields.upconfigure;
        end
    end

endmodule

//--- source/osChecker.sv
`timescale 1ns/100ps

module osChecker
#(
    parameter bit isUpstream = 1'b0
)
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       valid,
    input  osCheckPkg::orderedSet_t    orderedSet,
    input  osCheckPkg::ltssmSubstate_t substate,
    input  osCheckPkg::symbol_t        linkNumber,
    input  osCheckPkg::symbol_t        laneNumber,
    output logic                       countUp,
    output logic                       countKeep,
    output osCheckPkg::symbol_t        rateId,
    output osCheckPkg::symbol_t        linkNumberOut,
    output logic                       upconfigureCapable
);

    logic fieldsChanged;  // Rate or upconfigure differs from the last set.

    osFieldsIf decodedSet ();

    osDecoder i_osDecoder
    (
        .clk        (clk),
        .reset      (reset),
        .orderedSet (orderedSet),
        .valid      (valid),
        .fields     (decodedSet.producer)
    );

    osMatchFsm
    #(
        .isUpstream (isUpstream)
    )
    i_osMatchFsm
    (
        .clk           (clk),
        .reset         (reset),
        .substate      (substate),
        .linkNumber    (linkNumber),
        .laneNumber    (laneNumber),
        .fields        (decodedSet.consumer),
        .fieldsChanged (fieldsChanged),
        .countUp       (countUp),
        .countKeep     (countKeep)
    );

    osCapture i_osCapture
    (
        .clk                (clk),
        .reset              (reset),
        .fields             (decodedSet.consumer),
        .fieldsChanged      (fieldsChanged),
        .rateId             (rateId),
        .linkNumberOut      (linkNumberOut),
        .upconfigureCapable (upconfigureCapable)
    );

endmodule

//--- sim/osCheckerTasks.svh
`ifndef OS_CHECKER_TASKS_SVH
`define OS_CHECKER_TASKS_SVH

int errorCount   = 0;
int timeoutCount = 0;

// ############################################################################
// Random numbers and ordered-set builders
// ############################################################################

function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

function automatic osCheckPkg::orderedSet_t buildSet(
    input logic [7:0] start,
    input logic [7:0] link,
    input logic [7:0] lane,
    input logic [7:0] id,
    input logic [7:0] rate,
    input logic       upconfigure,
    input logic       compliance);
    osCheckPkg::orderedSet_t s;
    s          = '0;
    s[7:0]     = start;
    s[15:8]    = link;
    s[23:16]   = lane;
    s[39:32]   = rate;  // Symbol 4.
    s[42]      = upconfigure;
    s[43]      = compliance;
    s[87:80]   = id;  // Symbol 10.
    return s;
endfunction

// ############################################################################
// Reference match rule
// ############################################################################

function automatic logic expectMatch(
    input osCheckPkg::ltssmSubstate_t rule,
    input osCheckPkg::orderedSet_t    s,
    input logic [7:0]                 linkNum,
    input logic [7:0]                 laneNum,
    input logic [7:0]                 learned,
    input logic                       inRun,
    input logic                       changed,
    input logic                       upstream);
    logic ts1;
    logic ts2;
    logic linkPad;
    logic lanePad;
    logic linkEq;
    logic laneEq;
    ts1     = ((s[7:0] == 8'hBC) || (s[7:0] == 8'h1E)) && (s[87:80] == 8'h4A) && (s != '0);
    ts2     = ((s[7:0] == 8'hBC) || (s[7:0] == 8'h2D)) && (s[87:80] == 8'h45) && (s != '0);
    linkPad = (s[15:8] == 8'hF7);
    lanePad = (s[23:16] == 8'hF7);
    linkEq  = (s[15:8] == linkNum);
    laneEq  = (s[23:16] == laneNum);
    case (rule)
        osCheckPkg::pollingActive:
            return (ts2 || (ts1 && (!s[43] || s[42]))) && linkPad && lanePad;
        osCheckPkg::pollingConfiguration:
            return ts2 && linkPad && lanePad;
        osCheckPkg::configurationLinkWidthStart:
            if (upstream)
                return ts1 && lanePad && (inRun ? (s[15:8] == learned) : !linkPad);
            else
                return ts1 && lanePad && linkEq;
        osCheckPkg::configurationLinkWidthAccept:
            return upstream && ts1 && linkEq && !lanePad;
        osCheckPkg::configurationLanenumWait,
        osCheckPkg::configurationLanenumAccept:
            return (upstream ? ts2 : ts1) && linkEq && laneEq;
        osCheckPkg::configurationComplete:
            return ts2 && linkEq && laneEq && !(inRun && changed);
        osCheckPkg::configurationIdle:
            return (s == '0);
        default:
            return 1'b0;
    endcase
endfunction

`endif

//--- sim/osCheckerTb.sv
`timescale 1ns/100ps

module osCheckerTb
#(
    parameter bit          isUpstream = 1'b0,
    parameter logic [31:0] seed       = 32'hac2a_fbb0
);

    logic                       clk;
    logic                       reset;
    logic                       valid;
    osCheckPkg::orderedSet_t    orderedSet;
    osCheckPkg::ltssmSubstate_t substate;
    osCheckPkg::symbol_t        linkNumber;
    osCheckPkg::symbol_t        laneNumber;
    logic                       countUp;
    logic                       countKeep;
    osCheckPkg::symbol_t        rateId;
    osCheckPkg::symbol_t        linkNumberOut;
    logic                       upconfigureCapable;

    // Reference model state.
    logic                       rValid;
    osCheckPkg::orderedSet_t    rSet;
    logic [1:0]                 mState;  // 0 idle, 1 hunt, 2 run.
    osCheckPkg::ltssmSubstate_t heldSub;
    osCheckPkg::ltssmSubstate_t rule;
    logic [7:0]                 learned;
    logic [7:0]                 capRate;
    logic [7:0]                 capLink;
    logic                       capUp;
    logic                       changed;
    logic                       matchNow;
    logic                       expUp;
    logic                       expKeep;
    logic [31:0]                rnd;
    logic [7:0]                 roleId;
    osCheckPkg::orderedSet_t    randSet;

    `include "osCheckerTasks.svh"

    initial clk = 1'b0;
    always #50 clk = ~clk;

    osChecker #(.isUpstream (isUpstream)) i_osChecker
    (
        .clk                (clk),
        .reset              (reset),
        .valid              (valid),
        .orderedSet         (orderedSet),
        .substate           (substate),
        .linkNumber         (linkNumber),
        .laneNumber         (laneNumber),
        .countUp            (countUp),
        .countKeep          (countKeep),
        .rateId             (rateId),
        .linkNumberOut      (linkNumberOut),
        .upconfigureCapable (upconfigureCapable)
    );

    // ########################################################################
    // Reference model
    // ########################################################################

    always_comb
    begin
        rule     = (mState == 2'd0) ? substate : heldSub;
        changed  = rValid && ((rSet[39:32] != capRate) || (rSet[42] != capUp));
        matchNow = expectMatch(rule, rSet, linkNumber, laneNumber, learned,
                               mState == 2'd2, changed, isUpstream);
        expUp    = rValid && matchNow;
        expKeep  = (mState == 2'd2) || expUp;
    end

    always @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            rValid  <= 1'b0;
            rSet    <= '0;
            mState  <= 2'd0;
            heldSub <= osCheckPkg::detectQuiet;
            learned <= 8'h00;
            capRate <= 8'h00;
            capLink <= 8'h00;
            capUp   <= 1'b0;
        end
        else
        begin
            rValid <= valid;
            if (valid)
                rSet <= orderedSet;
            if (rValid)
            begin
                capRate <= rSet[39:32];
                capLink <= rSet[15:8];
                capUp   <= rSet[42];
            end
            if ((mState != 2'd0) && (substate != heldSub))
                mState <= 2'd0;  // Substate left.
            else if ((mState != 2'd2) && expUp)
                mState <= 2'd2;
            else if ((mState == 2'd2) && rValid && !matchNow)
                mState <= 2'd1;
            if ((mState == 2'd0) && expUp)
                heldSub <= substate;
            if (expUp && (mState != 2'd2) && (rule == osCheckPkg::configurationLinkWidthStart))
                learned <= rSet[15:8];
        end
    end

    // ########################################################################
    // Assertions
    // ########################################################################

    upCheck: assert property (@(negedge clk) disable iff (!reset) countUp == expUp)
        else
        begin
            errorCount++;
            $display("FAILED %0t countUp expected %0b actual %0b", $time, expUp, countUp);
        end
    keepCheck: assert property (@(negedge clk) disable iff (!reset) countKeep == expKeep)
        else
        begin
            errorCount++;
            $display("FAILED %0t countKeep expected %0b actual %0b",
                     $time, expKeep, countKeep);
        end
    rateCheck: assert property (@(negedge clk) disable iff (!reset) rateId == capRate)
        else
        begin
            errorCount++;
            $display("FAILED %0t rateId expected %h actual %h", $time, capRate, rateId);
        end
    linkCheck: assert property (@(negedge clk) disable iff (!reset) linkNumberOut == capLink)
        else
        begin
            errorCount++;
            $display("FAILED %0t linkNumberOut expected %h actual %h",
                     $time, capLink, linkNumberOut);
        end
    upcfgCheck: assert property (@(negedge clk) disable iff (!reset) upconfigureCapable == capUp)
        else
        begin
            errorCount++;
            $display("FAILED %0t upconfigureCapable expected %0b actual %0b",
                     $time, capUp, upconfigureCapable);
        end

    // ########################################################################
    // Stimulus
    // ########################################################################

    task automatic sendSet(input osCheckPkg::orderedSet_t s);
        @(posedge clk);
        orderedSet <= s;
        valid      <= 1'b1;
        @(posedge clk);
        valid      <= 1'b0;
    endtask

    task automatic enterSubstate(input osCheckPkg::ltssmSubstate_t st);
        @(posedge clk);
        substate <= st;
        repeat (2) @(posedge clk);  // Machine sits in idle meanwhile.
    endtask

    task automatic waitForCountUp();
        logic seen;
        seen = 1'b0;
        for (int i = 0; (i < 4) && !seen; i++)
        begin
            @(negedge clk);
            seen = countUp;
        end
        if (!seen)
        begin
            timeoutCount++;
            $display("Timeout at %0t: no count pulse after a matching set", $time);
        end
    endtask

    initial
    begin
        #5_000_000;
        $display("Timeout: the test did not reach its end");
        $display("Regression failed");
        $finish;
    end

    initial
    begin
        reset      = 1'b0;
        valid      = 1'b0;
        orderedSet = '0;
        substate   = osCheckPkg::detectQuiet;
        linkNumber = 8'h00;
        laneNumber = 8'h00;
        rnd        = seed;
        roleId     = isUpstream ? 8'h45 : 8'h4A;
        repeat (3) @(posedge clk);
        reset <= 1'b1;
        repeat (3) @(posedge clk);

        enterSubstate(osCheckPkg::pollingActive);
        sendSet(buildSet(8'hBC, 8'hF7, 8'hF7, 8'h4A, 8'h01, 1'b0, 1'b0));
        waitForCountUp();
        sendSet(buildSet(8'h1E, 8'hF7, 8'hF7, 8'h4A, 8'h01, 1'b1, 1'b1));
        sendSet(buildSet(8'hBC, 8'hF7, 8'hF7, 8'h45, 8'h01, 1'b0, 1'b0));
        sendSet(buildSet(8'hBC, 8'hF7, 8'hF7, 8'h4A, 8'h01, 1'b0, 1'b1));
        sendSet(buildSet(8'hBC, 8'hF7, 8'hF7, 8'h00, 8'h01, 1'b0, 1'b0));
        sendSet(buildSet(8'hBC, 8'hF7, 8'hF7, 8'h4A, 8'h01, 1'b0, 1'b0));
        sendSet(buildSet(8'hBC, 8'h05, 8'hF7, 8'h45, 8'h01, 1'b0, 1'b0));

        enterSubstate(osCheckPkg::pollingConfiguration);
        sendSet(buildSet(8'h2D, 8'hF7, 8'hF7, 8'h45, 8'h01, 1'b0, 1'b0));
        waitForCountUp();
        sendSet(buildSet(8'h2D, 8'hF7, 8'hF7, 8'h45, 8'h01, 1'b0, 1'b0));
        sendSet(buildSet(8'hBC, 8'hF7, 8'hF7, 8'h4A, 8'h01, 1'b0, 1'b0));

        @(posedge clk);
        linkNumber <= 8'h05;
        laneNumber <= 8'h00;
        enterSubstate(osCheckPkg::configurationLinkWidthStart);
        sendSet(buildSet(8'hBC, 8'h05, 8'hF7, 8'h4A, 8'h02, 1'b0, 1'b0));
        waitForCountUp();
        sendSet(buildSet(8'hBC, 8'h05, 8'hF7, 8'h4A, 8'h02, 1'b0, 1'b0));
        sendSet(buildSet(8'hBC, 8'h06, 8'hF7, 8'h4A, 8'h02, 1'b0, 1'b0));
        sendSet(buildSet(8'hBC, 8'h05, 8'hF7, 8'h4A, 8'h02, 1'b0, 1'b0));
        // Upstream learns 09 here, so the following 05 must mismatch.
        sendSet(buildSet(8'hBC, 8'h09, 8'hF7, 8'h4A, 8'h02, 1'b0, 1'b0));
        sendSet(buildSet(8'hBC, 8'h09, 8'hF7, 8'h4A, 8'h02, 1'b0, 1'b0));
        sendSet(buildSet(8'hBC, 8'h05, 8'hF7, 8'h4A, 8'h02, 1'b0, 1'b0));

        enterSubstate(osCheckPkg::configurationLinkWidthAccept);
        sendSet(buildSet(8'hBC, 8'h05, 8'h00, 8'h4A, 8'h02, 1'b0, 1'b0));
        sendSet(buildSet(8'hBC, 8'h05, 8'hF7, 8'h4A, 8'h02, 1'b0, 1'b0));

        enterSubstate(osCheckPkg::configurationLanenumWait);
        sendSet(buildSet(8'hBC, 8'h05, 8'h00, roleId, 8'h02, 1'b0, 1'b0));
        waitForCountUp();
        sendSet(buildSet(8'hBC, 8'h05, 8'h00, roleId ^ 8'h0F, 8'h02, 1'b0, 1'b0));
        sendSet(buildSet(8'hBC, 8'h05, 8'h00, roleId, 8'h02, 1'b0, 1'b0));
        sendSet(buildSet(8'hBC, 8'h06, 8'h00, roleId, 8'h02, 1'b0, 1'b0));

        enterSubstate(osCheckPkg::configurationLanenumAccept);
        sendSet(buildSet(8'hBC, 8'h05, 8'h00, roleId, 8'h02, 1'b0, 1'b0));
        waitForCountUp();
        sendSet(buildSet(8'hBC, 8'h05, 8'h01, roleId, 8'h02, 1'b0, 1'b0));

        enterSubstate(osCheckPkg::configurationComplete);
        sendSet(buildSet(8'hBC, 8'h05, 8'h00, 8'h45, 8'h02, 1'b0, 1'b0));
        waitForCountUp();
        sendSet(buildSet(8'hBC, 8'h05, 8'h00, 8'h45, 8'h02, 1'b0, 1'b0));
        sendSet(buildSet(8'hBC, 8'h05, 8'h00, 8'h45, 8'h03, 1'b0, 1'b0));
        sendSet(buildSet(8'hBC, 8'h05, 8'h00, 8'h45, 8'h03, 1'b0, 1'b0));
        sendSet(buildSet(8'hBC, 8'h05, 8'h00, 8'h45, 8'h03, 1'b1, 1'b0));

        enterSubstate(osCheckPkg::configurationIdle);
        sendSet('0);
        waitForCountUp();
        sendSet('0);
        sendSet(buildSet(8'h00, 8'h00, 8'h00, 8'h00, 8'h01, 1'b0, 1'b0));

        enterSubstate(osCheckPkg::detectQuiet);
        repeat (24)
        begin
            for (int w = 0; w < 4; w++)
            begin
                rnd = xorshift(rnd);
                randSet[w * 32 +: 32] = rnd;
            end
            sendSet(randSet);
        end
        repeat (4) @(posedge clk);

        $display("Checks done: %0d errors, %0d timeouts", errorCount, timeoutCount);
        if ((errorCount == 0) && (timeoutCount == 0))
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

//--- osChecker.f
+incdir+sim
source/osCheckPkg.sv
source/osFieldsIf.sv
source/osDecoder.sv
source/osMatchFsm.sv
source/osCapture.sv
source/osChecker.sv
sim/osCheckerTb.sv

//--- Makefile
# Verilator build and run for the ordered-set checker.

VERILATOR ?= verilator
TOP       ?= osCheckerTb
FILELIST  ?= osChecker.f
ROLE      ?= 0 1
SEED      ?= 32'hac2a_fbb0
OBJ       ?= obj_dir
LOG       ?= sim
VFLAGS    ?= --binary --timing --assert --top-module $(TOP)

.PHONY: all run lint clean

all: run

run:
	@set -e; for r in $(ROLE); do \
		$(VERILATOR) $(VFLAGS) -GisUpstream=$$r -Gseed="$(SEED)" \
			--Mdir $(OBJ)_$$r -f $(FILELIST); \
		./$(OBJ)_$$r/V$(TOP) | tee $(LOG)_$$r.log; \
		grep -q "Regression passed" $(LOG)_$$r.log; \
	done

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ)_* $(LOG)_*.log
